// ==== hdl/tlb_pkg.sv ====
package tlb_pkg;

    localparam int tlb_entry_num = 16;
    localparam int tlb_idx_wid   = 4;
    localparam int ps_small      = 12;
    localparam int ps_large      = 21;

    localparam logic [5:0] ecode_tlbr = 6'h3f; // TLB refill

    // APB register map
    localparam logic [7:0] addr_tlbidx   = 8'h00;
    localparam logic [7:0] addr_tlbehi   = 8'h04;
    localparam logic [7:0] addr_tlbelo0  = 8'h08;
    localparam logic [7:0] addr_tlbelo1  = 8'h0C;
    localparam logic [7:0] addr_asid     = 8'h10;
    localparam logic [7:0] addr_ecode    = 8'h14;
    localparam logic [7:0] addr_op       = 8'h18;
    localparam logic [7:0] addr_inv_asid = 8'h1C;
    localparam logic [7:0] addr_inv_va   = 8'h20;

    typedef logic [tlb_idx_wid-1:0] tlb_idx_t;

    typedef struct packed {
        tlb_idx_t   index;
        logic [5:0] ps;
        logic       ne;
    } tlbidx_t;

    typedef struct packed {
        logic [18:0] vppn; // VA[31:13], one page pair
    } tlbehi_t;

    typedef struct packed {
        logic        v;
        logic        d;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        g;
        logic [19:0] ppn;
    } tlbelo_t;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic            e;
        logic            g;
        logic [9:0]      asid;
        logic [18:0]     vppn;
        logic [5:0]      ps;
        tlb_page_t [1:0] page; // Index 1 is the odd page
    } tlb_entry_t;

    typedef tlb_entry_t [tlb_entry_num-1:0] tlb_entries_t;

    typedef struct packed {
        tlbidx_t       tlbidx;
        tlbehi_t       tlbehi;
        tlbelo_t [1:0] tlbelo;
        logic [9:0]    asid;
        logic [5:0]    ecode;
    } csr_t;

    typedef enum logic [2:0] {
        TLBNOP, TLBSRCH, TLBRD, TLBWR, TLBFILL, INVTLB
    } tlb_op_e;

    typedef enum logic [4:0] {
        INV_ALL0, INV_ALL1, INV_GLB, INV_NGLB, INV_ASID, INV_ASID_VA, INV_GA_VA
    } inv_op_e;

    typedef struct packed {
        tlb_op_e     op;
        inv_op_e     inv_op;
        logic [9:0]  inv_asid;
        logic [18:0] inv_vppn;
    } tlb_op_req_t;

    typedef struct packed {
        logic          we;
        tlbidx_t       tlbidx;
        tlbehi_t       tlbehi;
        tlbelo_t [1:0] tlbelo;
        logic [9:0]    asid;
    } csr_wb_t;

    typedef struct packed {
        logic       we;
        tlb_idx_t   idx;
        tlb_entry_t data;
    } tlb_wr_t;

    typedef struct packed {
        logic        hit;
        tlb_idx_t    idx;
        logic [31:0] pa;
        tlb_page_t   page;
    } tlb_match_t;

    // For 2 MiB pages the low 9 vppn bits fall inside the page pair
    function automatic logic vppn_hit(tlb_entry_t ent, logic [18:0] vppn);
        logic [18:0] mask;
        mask = (ent.ps == ps_large) ? 19'h7fe00 : 19'h7ffff;
        return ((ent.vppn ^ vppn) & mask) == '0;
    endfunction

endpackage

// ==== hdl/tlb_apb_regs.sv ====
`timescale 1ns/100ps

module tlb_apb_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    output tlb_pkg::csr_t        csr,
    output tlb_pkg::tlb_op_req_t op_req,
    input  tlb_pkg::csr_wb_t     csr_wb
);
    import tlb_pkg::*;

    logic        wr_en;
    logic        mapped;
    tlb_op_e     op_q;
    inv_op_e     inv_op_q;
    logic [9:0]  inv_asid_q;
    logic [18:0] inv_vppn_q;

    function automatic logic [31:0] elo_pack(tlbelo_t elo);
        return {4'b0, elo.ppn, 1'b0, elo.g, elo.mat, elo.plv, elo.d, elo.v};
    endfunction

    function automatic tlbelo_t elo_unpack(logic [31:0] data);
        tlbelo_t elo;
        elo.v   = data[0];
        elo.d   = data[1];
        elo.plv = data[3:2];
        elo.mat = data[5:4];
        elo.g   = data[6];
        elo.ppn = data[27:8];
        return elo;
    endfunction

    assign wr_en   = psel & penable & pwrite; // End of access phase
    assign pready  = 1'b1;
    assign pslverr = psel & penable & ~mapped;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            addr_tlbidx:   prdata = {csr.tlbidx.ne, 1'b0, csr.tlbidx.ps, 20'b0,
                                     csr.tlbidx.index};
            addr_tlbehi:   prdata = {csr.tlbehi.vppn, 13'b0};
            addr_tlbelo0:  prdata = elo_pack(csr.tlbelo[0]);
            addr_tlbelo1:  prdata = elo_pack(csr.tlbelo[1]);
            addr_asid:     prdata = {22'b0, csr.asid};
            addr_ecode:    prdata = {26'b0, csr.ecode};
            addr_op:       prdata = '0; // Write only
            addr_inv_asid: prdata = {22'b0, inv_asid_q};
            addr_inv_va:   prdata = {inv_vppn_q, 13'b0};
            default:       mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr        <= '0;
            op_q       <= TLBNOP;
            inv_op_q   <= INV_ALL0;
            inv_asid_q <= '0;
            inv_vppn_q <= '0;
        end else begin
            op_q <= TLBNOP;
            if (csr_wb.we) begin
                csr.tlbidx <= csr_wb.tlbidx;
                csr.tlbehi <= csr_wb.tlbehi;
                csr.tlbelo <= csr_wb.tlbelo;
                csr.asid   <= csr_wb.asid;
            end
            // APB write comes last so it overrides a writeback to the same field
            if (wr_en) begin
                case (paddr)
                    addr_tlbidx: begin
                        csr.tlbidx.index <= pwdata[3:0];
                        csr.tlbidx.ps    <= pwdata[29:24];
                        csr.tlbidx.ne    <= pwdata[31];
                    end
                    addr_tlbehi:   csr.tlbehi.vppn <= pwdata[31:13];
                    addr_tlbelo0:  csr.tlbelo[0]   <= elo_unpack(pwdata);
                    addr_tlbelo1:  csr.tlbelo[1]   <= elo_unpack(pwdata);
                    addr_asid:     csr.asid        <= pwdata[9:0];
                    addr_ecode:    csr.ecode       <= pwdata[5:0];
                    addr_op: begin
                        op_q     <= tlb_op_e'(pwdata[2:0]);
                        inv_op_q <= inv_op_e'(pwdata[12:8]);
                    end
                    addr_inv_asid: inv_asid_q      <= pwdata[9:0];
                    addr_inv_va:   inv_vppn_q      <= pwdata[31:13];
                    default: ;
                endcase
            end
        end
    end

    // op is a one cycle pulse, INVTLB operands stay put
    assign op_req = '{op: op_q, inv_op: inv_op_q, inv_asid: inv_asid_q, inv_vppn: inv_vppn_q};

endmodule

// ==== hdl/tlb_ctrl.sv ====
`timescale 1ns/100ps

module tlb_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tlb_pkg::csr_t         csr,
    input  tlb_pkg::tlb_op_req_t  op_req,
    input  tlb_pkg::tlb_entries_t entries,
    input  tlb_pkg::tlb_match_t   srch,
    output tlb_pkg::tlb_wr_t      wr,
    output logic                  inv_en,
    output tlb_pkg::csr_wb_t      csr_wb
);
    import tlb_pkg::*;

    typedef enum logic {IDLE, EXEC} state_e;

    state_e     state;
    tlb_op_e    op_q;
    tlb_idx_t   fill_cnt;
    tlb_entry_t new_ent;
    tlb_entry_t rd_ent;
    csr_wb_t    wb_d;
    csr_wb_t    wb_q;
    tlb_idx_t   wr_idx_q;
    tlb_entry_t wr_data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            op_q     <= TLBNOP;
            fill_cnt <= '0;
        end else begin
            fill_cnt <= fill_cnt + 1'b1; // Free running, picks the TLBFILL slot
            op_q     <= op_req.op;
            state    <= (op_req.op == TLBNOP) ? IDLE : EXEC;
        end
    end

    always_ff @(posedge clk) begin
        if (op_req.op != TLBNOP) begin
            wr_idx_q  <= (op_req.op == TLBFILL) ? fill_cnt : csr.tlbidx.index;
            wr_data_q <= new_ent;
            wb_q      <= wb_d;
        end
    end

    // Entry image built from the CSRs
    always_comb begin
        new_ent.e    = (csr.ecode == ecode_tlbr) ? ~csr.tlbidx.ne : 1'b1;
        new_ent.g    = csr.tlbelo[0].g & csr.tlbelo[1].g;
        new_ent.asid = csr.asid;
        new_ent.vppn = csr.tlbehi.vppn;
        new_ent.ps   = csr.tlbidx.ps;
        for (int j = 0; j < 2; j++) begin
            new_ent.page[j].ppn = csr.tlbelo[j].ppn;
            new_ent.page[j].plv = csr.tlbelo[j].plv;
            new_ent.page[j].mat = csr.tlbelo[j].mat;
            new_ent.page[j].d   = csr.tlbelo[j].d;
            new_ent.page[j].v   = csr.tlbelo[j].v;
        end
    end

    always_comb begin
        rd_ent      = entries[csr.tlbidx.index];
        wb_d.we     = 1'b1;
        wb_d.tlbidx = csr.tlbidx;
        wb_d.tlbehi = csr.tlbehi;
        wb_d.tlbelo = csr.tlbelo;
        wb_d.asid   = csr.asid;
        case (op_req.op)
            TLBSRCH: begin
                wb_d.tlbidx.ne = ~srch.hit;
                if (srch.hit)
                    wb_d.tlbidx.index = srch.idx; // Index kept on a miss
            end
            TLBRD: begin
                if (rd_ent.e) begin
                    wb_d.tlbidx.ne   = 1'b0;
                    wb_d.tlbidx.ps   = rd_ent.ps;
                    wb_d.tlbehi.vppn = rd_ent.vppn;
                    wb_d.asid        = rd_ent.asid;
                    for (int j = 0; j < 2; j++) begin
                        wb_d.tlbelo[j].ppn = rd_ent.page[j].ppn;
                        wb_d.tlbelo[j].plv = rd_ent.page[j].plv;
                        wb_d.tlbelo[j].mat = rd_ent.page[j].mat;
                        wb_d.tlbelo[j].d   = rd_ent.page[j].d;
                        wb_d.tlbelo[j].v   = rd_ent.page[j].v;
                        wb_d.tlbelo[j].g   = rd_ent.g;
                    end
                end else begin
                    wb_d.tlbidx.ne = 1'b1;
                    wb_d.tlbidx.ps = '0;
                    wb_d.tlbehi    = '0;
                    wb_d.tlbelo    = '0;
                    wb_d.asid      = '0;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        wr.we     = (state == EXEC) && (op_q == TLBWR || op_q == TLBFILL);
        wr.idx    = wr_idx_q;
        wr.data   = wr_data_q;
        inv_en    = (state == EXEC) && (op_q == INVTLB);
        csr_wb    = wb_q;
        csr_wb.we = (state == EXEC) && (op_q == TLBSRCH || op_q == TLBRD);
    end

endmodule

// ==== hdl/tlb_entry_array.sv ====
`timescale 1ns/100ps

module tlb_entry_array (
    input  logic                              clk,
    input  logic                              rst_n,
    input  tlb_pkg::tlb_wr_t                  wr,
    input  logic                              inv_en,
    input  logic [tlb_pkg::tlb_entry_num-1:0] inv_mask,
    output tlb_pkg::tlb_entries_t             entries
);
    import tlb_pkg::*;

    logic [tlb_entry_num-1:0] valid;           // The e bits
    tlb_entry_t               mem [tlb_entry_num];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (wr.we) begin
            valid[wr.idx] <= wr.data.e;
        end else if (inv_en) begin
            for (int i = 0; i < tlb_entry_num; i++) begin
                if (inv_mask[i])
                    valid[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we)
            mem[wr.idx] <= wr.data;
    end

    always_comb begin
        for (int i = 0; i < tlb_entry_num; i++) begin
            entries[i]   = mem[i];
            entries[i].e = valid[i];
        end
    end

endmodule

// ==== hdl/tlb_search.sv ====
`timescale 1ns/100ps

module tlb_search (
    input  tlb_pkg::tlb_entries_t entries,
    input  logic [31:0]           va,
    input  logic [9:0]            asid,
    output tlb_pkg::tlb_match_t   match
);
    import tlb_pkg::*;

    tlb_entry_t hit_ent;
    logic       odd;

    always_comb begin
        match   = '0;
        hit_ent = '0;
        odd     = 1'b0;
        // Later entries override earlier ones, highest index wins
        for (int i = 0; i < tlb_entry_num; i++) begin
            if (entries[i].e && (entries[i].g || entries[i].asid == asid) &&
                vppn_hit(entries[i], va[31:13])) begin
                match.hit = 1'b1;
                match.idx = tlb_idx_t'(i);
                hit_ent   = entries[i];
            end
        end
        if (match.hit) begin
            if (hit_ent.ps == ps_large) begin
                odd      = va[ps_large];
                match.pa = {hit_ent.page[odd].ppn[19:9], va[ps_large-1:0]};
            end else begin
                odd      = va[ps_small];
                match.pa = {hit_ent.page[odd].ppn, va[ps_small-1:0]};
            end
            match.page = hit_ent.page[odd];
        end
    end

endmodule

// ==== hdl/tlb_inv_filter.sv ====
`timescale 1ns/100ps

module tlb_inv_filter (
    input  tlb_pkg::tlb_op_req_t              op_req,
    input  tlb_pkg::tlb_entries_t             entries,
    output logic [tlb_pkg::tlb_entry_num-1:0] inv_mask
);
    import tlb_pkg::*;

    logic [tlb_entry_num-1:0] glb;
    logic [tlb_entry_num-1:0] asid_eq;
    logic [tlb_entry_num-1:0] va_eq;

    always_comb begin
        for (int i = 0; i < tlb_entry_num; i++) begin
            glb[i]     = entries[i].g;
            asid_eq[i] = entries[i].asid == op_req.inv_asid;
            va_eq[i]   = vppn_hit(entries[i], op_req.inv_vppn);
        end
    end

    // Ignores op_req.op on purpose. The operands are held, so the mask
    // is still valid one cycle later when inv_en arrives
    always_comb begin
        case (op_req.inv_op)
            INV_ALL0,
            INV_ALL1:    inv_mask = '1;
            INV_GLB:     inv_mask = glb;
            INV_NGLB:    inv_mask = ~glb;
            INV_ASID:    inv_mask = ~glb & asid_eq;
            INV_ASID_VA: inv_mask = ~glb & asid_eq & va_eq;
            INV_GA_VA:   inv_mask = (glb | asid_eq) & va_eq;
            default:     inv_mask = '0;
        endcase
    end

endmodule

// ==== hdl/tlb_mmu_top.sv ====
`timescale 1ns/100ps

module tlb_mmu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic [31:0]         lookup_va,
    output tlb_pkg::tlb_match_t lookup
);
    import tlb_pkg::*;

    csr_t                     csr;
    tlb_op_req_t              op_req;
    csr_wb_t                  csr_wb;
    tlb_wr_t                  wr;
    logic                     inv_en;
    logic [tlb_entry_num-1:0] inv_mask;
    tlb_entries_t             entries;
    tlb_match_t               srch;

    tlb_apb_regs regs_u (
        .clk, .rst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .csr, .op_req, .csr_wb
    );

    tlb_ctrl ctrl_u (
        .clk, .rst_n,
        .csr, .op_req, .entries, .srch,
        .wr, .inv_en, .csr_wb
    );

    tlb_entry_array array_u (
        .clk, .rst_n,
        .wr, .inv_en, .inv_mask,
        .entries
    );

    tlb_inv_filter inv_u (
        .op_req, .entries, .inv_mask
    );

    // TLBSRCH probe, vppn from TLBEHI
    tlb_search srch_u (
        .entries,
        .va    ({csr.tlbehi.vppn, 13'b0}),
        .asid  (csr.asid),
        .match (srch)
    );

    tlb_search look_u (
        .entries,
        .va    (lookup_va),
        .asid  (csr.asid),
        .match (lookup)
    );

endmodule

// ==== test/tlb_mmu_sva.sv ====
`timescale 1ns/100ps

module tlb_mmu_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic                 pslverr,
    input tlb_pkg::tlb_op_req_t op_req,
    input tlb_pkg::tlb_wr_t     wr,
    input logic                 inv_en
);
    import tlb_pkg::*;

    int fail_cnt = 0; // Polled by the testbench

    a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            $error("pready low");
            fail_cnt++;
        end

    a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> psel && penable)
        else begin
            $error("pslverr outside access phase");
            fail_cnt++;
        end

    // Op request is a single cycle pulse
    a_op_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        op_req.op != TLBNOP |=> op_req.op == TLBNOP)
        else begin
            $error("op_req held longer than one cycle");
            fail_cnt++;
        end

    a_wr_cause: assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |-> $past(op_req.op == TLBWR || op_req.op == TLBFILL))
        else begin
            $error("entry write without TLBWR or TLBFILL request");
            fail_cnt++;
        end

    a_inv_cause: assert property (@(posedge clk) disable iff (!rst_n)
        inv_en |-> $past(op_req.op == INVTLB))
        else begin
            $error("inv_en without INVTLB request");
            fail_cnt++;
        end

endmodule

bind tlb_mmu_top tlb_mmu_sva sva_u (
    .clk, .rst_n,
    .psel, .penable, .pready, .pslverr,
    .op_req, .wr, .inv_en
);

// ==== test/tb_tlb_mmu.sv ====
`timescale 1ns/100ps

module tb_tlb_mmu;
    import tlb_pkg::*;

    localparam int clk_ns      = 20;
    localparam int xfer_budget = 1200;  // Rough count of APB transfers in all tests
    localparam int slack_cyc   = 1000;  // Op waits and lookups on top

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] lookup_va;
    tlb_match_t  lookup;

    logic [31:0] lfsr;
    logic [9:0]  cur_asid;              // Mirror of the ASID CSR
    tlb_entry_t  model [tlb_entry_num];

    tlb_mmu_top dut (
        .clk, .rst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .lookup_va, .lookup
    );

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    initial begin
        #(longint'(xfer_budget * 3 + slack_cyc) * clk_ns);
        $display("Simulation timed out before all tests completed");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    task automatic report_error(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "Stopping at first error");
    endtask

    // Bound assertions count their failures
    always @(negedge clk) begin
        if (dut.sva_u.fail_cnt != 0)
            report_error("a bound protocol or timing assertion failed");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic tlb_entry_t rand_entry(input logic [5:0] ps);
        tlb_entry_t  ent;
        logic [31:0] r;
        int          j;
        ent.e    = 1'b1;
        ent.g    = 1'b0;
        r        = rand_bits(10);
        ent.asid = r[9:0];
        r        = rand_bits(19);
        ent.vppn = r[18:0];
        ent.ps   = ps;
        for (j = 0; j < 2; j++) begin
            r           = rand_bits(26);
            ent.page[j] = r[25:0];
        end
        return ent;
    endfunction

    function automatic logic same_pair(input tlb_entry_t ent, input logic [18:0] vppn);
        if (ent.ps == 6'(ps_large))
            return ent.vppn[18:9] == vppn[18:9];  // 2 MiB pair spans 4 MiB
        return ent.vppn == vppn;
    endfunction

    function automatic tlb_match_t model_lookup(input logic [31:0] va, input logic [9:0] asid);
        tlb_match_t  m;
        tlb_entry_t  ent;
        logic [31:0] mask;
        int          ps;
        int          i;
        m = '0;
        for (i = 0; i < tlb_entry_num; i++) begin
            if (model[i].e && (model[i].g || model[i].asid == asid) &&
                same_pair(model[i], va[31:13])) begin
                m.hit = 1'b1;
                m.idx = tlb_idx_t'(i);
            end
        end
        if (m.hit) begin
            ent    = model[m.idx];
            ps     = (ent.ps == 6'(ps_large)) ? ps_large : ps_small;
            mask   = (32'h1 << ps) - 32'h1;
            m.page = ent.page[va[ps]];
            m.pa   = ({m.page.ppn, 12'h000} & ~mask) | (va & mask);
        end
        return m;
    endfunction

    function automatic logic inv_hit(input tlb_entry_t ent, input int op,
                                     input logic [9:0] asid, input logic [18:0] vppn);
        case (op)
            0, 1: return 1'b1;
            2: return ent.g;
            3: return !ent.g;
            4: return !ent.g && ent.asid == asid;
            5: return !ent.g && ent.asid == asid && same_pair(ent, vppn);
            6: return (ent.g || ent.asid == asid) && same_pair(ent, vppn);
            default: return 1'b0;
        endcase
    endfunction

    // Random VA inside the even or odd page of an entry
    function automatic logic [31:0] page_va(input tlb_entry_t ent, input logic odd);
        logic [31:0] va;
        int          ps;
        ps = (ent.ps == 6'(ps_large)) ? ps_large : ps_small;
        va = {ent.vppn, 13'b0} & ~((32'h1 << (ps + 1)) - 32'h1);
        va = va | (32'(odd) << ps) | (rand_bits(ps) & ((32'h1 << ps) - 32'h1));
        return va;
    endfunction

    function automatic logic [31:0] idx_word(input logic ne, input logic [5:0] ps,
                                             input tlb_idx_t index);
        return {ne, 1'b0, ps, 20'b0, index};
    endfunction

    function automatic logic [31:0] elo_word(input tlb_page_t page, input logic g);
        return {4'b0, page.ppn, 1'b0, g, page.mat, page.plv, page.d, page.v};
    endfunction

    task automatic apb_xfer(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);                 // End of access phase
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        assert (!err) else report_error($sformatf("pslverr on write to %h", addr));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        assert (!err) else report_error($sformatf("pslverr on read of %h", addr));
    endtask

    task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        apb_read(addr, rd);
        assert (rd == exp)
            else report_error($sformatf("reg %h read %h, expected %h", addr, rd, exp));
    endtask

    task automatic run_op(input tlb_op_e op, input inv_op_e inv);
        apb_write(addr_op, {19'b0, 5'(inv), 5'b0, 3'(op)});
        repeat (2) @(negedge clk);      // Results land two edges after the op write
    endtask

    task automatic write_asid(input logic [9:0] asid);
        apb_write(addr_asid, {22'b0, asid});
        cur_asid = asid;
    endtask

    task automatic load_csrs(input tlb_entry_t ent, input logic g0, input logic g1,
                             input logic ne, input tlb_idx_t index);
        apb_write(addr_tlbidx, idx_word(ne, ent.ps, index));
        apb_write(addr_tlbehi, {ent.vppn, 13'b0});
        apb_write(addr_tlbelo0, elo_word(ent.page[0], g0));
        apb_write(addr_tlbelo1, elo_word(ent.page[1], g1));
        write_asid(ent.asid);
    endtask

    task automatic write_entry(input tlb_idx_t idx, input tlb_entry_t ent,
                               input logic g0, input logic g1);
        load_csrs(ent, g0, g1, 1'b0, idx);
        run_op(TLBWR, INV_ALL0);
        ent.e      = 1'b1;
        ent.g      = g0 & g1;
        model[idx] = ent;
    endtask

    task automatic check_read(input tlb_idx_t idx);
        tlb_entry_t ent;
        apb_write(addr_tlbidx, idx_word(1'b0, 6'd0, idx));
        run_op(TLBRD, INV_ALL0);
        ent = model[idx];
        if (ent.e) begin
            expect_reg(addr_tlbidx, idx_word(1'b0, ent.ps, idx));
            expect_reg(addr_tlbehi, {ent.vppn, 13'b0});
            expect_reg(addr_tlbelo0, elo_word(ent.page[0], ent.g));
            expect_reg(addr_tlbelo1, elo_word(ent.page[1], ent.g));
            expect_reg(addr_asid, {22'b0, ent.asid});
            cur_asid = ent.asid;
        end else begin
            expect_reg(addr_tlbidx, idx_word(1'b1, 6'd0, idx));
            expect_reg(addr_tlbehi, 32'h0);
            expect_reg(addr_tlbelo0, 32'h0);
            expect_reg(addr_tlbelo1, 32'h0);
            expect_reg(addr_asid, 32'h0);
            cur_asid = '0;
        end
    endtask

    task automatic check_srch(input logic [18:0] vppn, input logic [9:0] asid);
        tlb_match_t exp;
        apb_write(addr_tlbidx, idx_word(1'b0, 6'd0, 4'hf)); // Index 15 stays on a miss
        apb_write(addr_tlbehi, {vppn, 13'b0});
        write_asid(asid);
        run_op(TLBSRCH, INV_ALL0);
        exp = model_lookup({vppn, 13'b0}, asid);
        expect_reg(addr_tlbidx, idx_word(~exp.hit, 6'd0, exp.hit ? exp.idx : 4'hf));
    endtask

    task automatic check_lookup(input logic [31:0] va);
        tlb_match_t exp;
        exp = model_lookup(va, cur_asid);
        @(negedge clk);
        lookup_va = va;
        @(posedge clk);
        assert (lookup.hit == exp.hit && (!exp.hit || lookup == exp))
            else report_error($sformatf("lookup va %h asid %h gave %h, expected %h",
                                        va, cur_asid, lookup, exp));
    endtask

    initial begin
        tlb_entry_t  ent;
        logic [31:0] rd;
        logic [31:0] r;
        logic        err;
        logic        g0;
        logic        g1;
        logic [18:0] pool [4];
        logic [9:0]  asid_a;
        logic [9:0]  asid_b;
        int          i;
        int          k;

        lfsr      = 32'h2b0476c7;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        lookup_va = '0;
        cur_asid  = '0;
        for (i = 0; i < tlb_entry_num; i++)
            model[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values and address decode
        for (i = 0; i <= 8; i++)
            expect_reg(8'(i * 4), 32'h0);
        check_lookup(rand_bits(32));
        apb_xfer(1'b0, 8'h24, 32'h0, rd, err);
        assert (err) else report_error("no pslverr on read of unmapped address 24");
        apb_xfer(1'b1, 8'h3c, 32'hffff_ffff, rd, err);
        assert (err) else report_error("no pslverr on write to unmapped address 3c");

        // TLBWR then TLBRD, mixed g bits and page sizes
        for (i = 0; i < 8; i++) begin
            ent = rand_entry((i % 2) ? 6'(ps_large) : 6'(ps_small));
            g0  = (i % 4 != 2);
            g1  = (i % 2 == 0);
            write_entry(tlb_idx_t'(i), ent, g0, g1);
        end
        for (i = 0; i < 8; i++)
            check_read(tlb_idx_t'(i));
        check_read(4'd12);              // Never written

        // TLBSRCH under own and foreign ASID
        for (i = 0; i < 8; i++) begin
            check_srch(model[i].vppn, model[i].asid);
            check_srch(model[i].vppn, model[i].asid ^ 10'h2a5);
        end
        r = rand_bits(19);
        check_srch(r[18:0], cur_asid);

        // Lookup translation, both halves of each pair
        for (i = 0; i < 8; i++) begin
            write_asid(model[i].asid);
            check_lookup(page_va(model[i], 1'b0));
            check_lookup(page_va(model[i], 1'b1));
        end
        for (i = 0; i < 4; i++)
            check_lookup(rand_bits(32));

        // TLBFILL, refill case first on an empty TLB
        run_op(INVTLB, INV_ALL0);
        for (i = 0; i < tlb_entry_num; i++)
            model[i].e = 1'b0;
        ent = rand_entry(6'(ps_small));
        apb_write(addr_ecode, {26'b0, ecode_tlbr});
        load_csrs(ent, 1'b0, 1'b0, 1'b1, 4'h0);
        run_op(TLBFILL, INV_ALL0);
        check_srch(ent.vppn, ent.asid); // Must miss
        apb_write(addr_ecode, 32'h0);
        load_csrs(ent, 1'b0, 1'b0, 1'b1, 4'h0);
        run_op(TLBFILL, INV_ALL0);
        apb_write(addr_tlbidx, idx_word(1'b0, 6'd0, 4'hf));
        run_op(TLBSRCH, INV_ALL0);
        apb_read(addr_tlbidx, rd);
        assert (rd[31] == 1'b0) else report_error("filled entry not found by TLBSRCH");
        model[rd[3:0]] = ent;           // Slot comes from the free running counter
        check_read(rd[3:0]);
        check_lookup(page_va(ent, 1'b1));

        // INVTLB sub-ops over global and ASID entries sharing a few VAs
        for (k = 0; k < 4; k++) begin
            r       = rand_bits(19);
            pool[k] = r[18:0];
        end
        r      = rand_bits(10);
        asid_a = r[9:0];
        asid_b = asid_a ^ 10'h0f0;
        for (k = 0; k < 7; k++) begin
            for (i = 0; i < tlb_entry_num; i++) begin
                ent      = rand_entry((i % 2) ? 6'(ps_large) : 6'(ps_small));
                ent.vppn = (i % 2) ? {pool[(i / 2) % 4][18:9], ent.vppn[8:0]} : pool[i % 4];
                ent.asid = ((i / 2) % 2) ? asid_b : asid_a;
                g0       = (i % 3 == 0);
                write_entry(tlb_idx_t'(i), ent, g0, g0);
            end
            apb_write(addr_inv_asid, {22'b0, asid_a});
            apb_write(addr_inv_va, {pool[0], 13'b0});
            run_op(INVTLB, inv_op_e'(k));
            for (i = 0; i < tlb_entry_num; i++) begin
                if (inv_hit(model[i], k, asid_a, pool[0]))
                    model[i].e = 1'b0;
            end
            for (i = 0; i < tlb_entry_num; i++) begin
                write_asid(model[i].asid);
                check_lookup(page_va(model[i], rand_bits(1) != 0));
            end
        end

        if (dut.sva_u.fail_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Bound assertions failed");
        end
    end

endmodule

// ==== files.f ====
hdl/tlb_pkg.sv
hdl/tlb_apb_regs.sv
hdl/tlb_ctrl.sv
hdl/tlb_entry_array.sv
hdl/tlb_search.sv
hdl/tlb_inv_filter.sv
hdl/tlb_mmu_top.sv
test/tlb_mmu_sva.sv
test/tb_tlb_mmu.sv
